// File: flist.f
+incdir+include
src/cpu_pkg.sv
src/word_ram.sv
src/reg_file.sv
src/alu.sv
src/host_port.sv
src/core_ctrl.sv
src/cpu_top.sv
bench/tb_cpu.sv

// File: Bender.yml
package:
  name: multicycle_cpu

sources:
  - include_dirs:
      - include
    files:
      - src/cpu_pkg.sv
      - src/word_ram.sv
      - src/reg_file.sv
      - src/alu.sv
      - src/host_port.sv
      - src/core_ctrl.sv
      - src/cpu_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/tb_cpu.sv

// File: bench/tb_cpu.sv
module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    // Opcode numbers of the instruction set
    localparam int OP_RTYPE = 0;
    localparam int OP_ADDI  = 1;
    localparam int OP_AND   = 3;
    localparam int OP_OR    = 4;
    localparam int OP_ANDI  = 5;
    localparam int OP_ORI   = 6;
    localparam int OP_SHIFT = 7;
    localparam int OP_LW    = 8;
    localparam int OP_SW    = 9;
    localparam int OP_BEQ   = 10;
    localparam int OP_BNE   = 11;
    localparam int OP_J     = 16;
    localparam int OP_SLT   = 19;
    localparam int OP_SLTI  = 20;

    // Bus word address 256 and up lands in data memory
    localparam int DMEM = 256;

    localparam int BUS_TIMEOUT = 4000;
    localparam int RUN_TIMEOUT = 4000;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              start;
    logic              running;
    logic              halted;
    cpu_pkg::wb_req_t  wb_req;
    cpu_pkg::wb_rsp_t  wb_rsp;

    integer seed;
    int     errors;
    int     timeouts;

    cpu_top i_cpu_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .start   (start),
        .running (running),
        .halted  (halted)
    );

    always #4 clk = ~clk;

    // The host never gets an answer while the core owns the memories
    a_no_ack_running: assert property (
        @(posedge clk) disable iff (!rst_n) running |-> !wb_rsp.ack
    ) else begin
        errors++;
        $display("MISMATCH at %0t: ack seen while the core is running", $time);
    end

    // Each ack is a single clock pulse
    a_ack_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) wb_rsp.ack |=> !wb_rsp.ack
    ) else begin
        errors++;
        $display("MISMATCH at %0t: ack stayed high for a second cycle", $time);
    end

    // Once halted the core stays halted until the next reset
    a_halt_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> halted && !running
    ) else begin
        errors++;
        $display("MISMATCH at %0t: halted dropped or running rose after halt", $time);
    end

    // Instruction word builders for the three formats
    function automatic logic [31:0] rtype(input int op, input int rs, input int rt,
                                          input int rd, input int shamt, input int funct);
        return {op[5:0], rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct[5:0]};
    endfunction

    function automatic logic [31:0] itype(input int op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op[5:0], rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [31:0] jtype(input int op, input int target);
        return {op[5:0], target[25:0]};
    endfunction

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n  = 1'b0;
        start  = 1'b0;
        wb_req = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // One Wishbone write holds its request until ack and over the edge that takes it
    task automatic write_word(input int adr, input logic [31:0] data);
        int n;
        n = 0;
        @(negedge clk);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b1;
        wb_req.adr   = 9'(adr);
        wb_req.dat_w = data;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_rsp.ack && n < BUS_TIMEOUT);
        if (wb_rsp.ack) begin
            @(negedge clk);
        end else begin
            timeouts++;
            $display("Timeout at %0t: bus write to address %0h was never acknowledged",
                     $time, adr);
        end
        wb_req = '0;
    endtask

    // One Wishbone read takes the word while ack is high
    task automatic read_word(input int adr, output logic [31:0] data);
        int n;
        n    = 0;
        data = 'x;
        @(negedge clk);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b0;
        wb_req.adr   = 9'(adr);
        wb_req.dat_w = '0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_rsp.ack && n < BUS_TIMEOUT);
        if (wb_rsp.ack) begin
            data = wb_rsp.dat_r;
            @(negedge clk);
        end else begin
            timeouts++;
            $display("Timeout at %0t: bus read of address %0h was never acknowledged",
                     $time, adr);
        end
        wb_req = '0;
    endtask

    // Instructions go to consecutive words from address 0
    task automatic load_program(input logic [31:0] words [$]);
        foreach (words[i]) begin
            write_word(i, words[i]);
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_for_halt();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!halted && n < RUN_TIMEOUT);
        if (!halted) begin
            timeouts++;
            $display("Timeout at %0t: the core did not halt within %0d cycles",
                     $time, RUN_TIMEOUT);
        end
    endtask

    task automatic check_reset_state();
        logic [31:0] v;
        logic [31:0] got;
        v = $random(seed);
        apply_reset();
        @(negedge clk);
        compare_word("running after reset", 32'(running), 32'd0);
        compare_word("halted after reset", 32'(halted), 32'd0);
        write_word(DMEM + 200, v);
        // A read that is already pending while reset is held gets no ack
        @(negedge clk);
        rst_n      = 1'b0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.adr = 9'(DMEM + 200);
        repeat (4) begin
            @(negedge clk);
            compare_word("ack while reset is held", 32'(wb_rsp.ack), 32'd0);
        end
        wb_req = '0;
        rst_n  = 1'b1;
        read_word(DMEM + 200, got);
        compare_word("data word read back before start", got, v);
    endtask

    // Every ALU operation runs on two loaded operands and each result is stored on its own
    task automatic alu_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] got;
        logic [31:0] sext1;
        logic [31:0] zext2;
        logic [15:0] imm1;
        logic [15:0] imm2;
        logic [4:0]  sh;
        logic [31:0] exp [$];
        logic [31:0] prog [$];
        string names [12] = '{"addi", "add", "sub", "and", "or", "andi", "ori",
                              "sll", "srl", "slt", "slti", "slt swapped"};
        a     = $random(seed);
        b     = $random(seed);
        imm1  = $random(seed);
        imm2  = $random(seed);
        sh    = $random(seed);
        sext1 = {{16{imm1[15]}}, imm1};
        zext2 = {16'h0000, imm2};
        apply_reset();
        write_word(DMEM + 0, a);
        write_word(DMEM + 1, b);
        // Nonzero so that the store from register 0 is visible
        write_word(DMEM + 40, 32'hffff_ffff);
        prog.push_back(itype(OP_LW, 0, 1, 0));
        prog.push_back(itype(OP_LW, 0, 2, 1));
        prog.push_back(itype(OP_ADDI, 1, 3, imm1));
        prog.push_back(rtype(OP_RTYPE, 1, 2, 4, 0, 0));
        prog.push_back(rtype(OP_RTYPE, 1, 2, 5, 0, 1));
        prog.push_back(rtype(OP_AND, 1, 2, 6, 0, 0));
        prog.push_back(rtype(OP_OR, 1, 2, 7, 0, 0));
        prog.push_back(itype(OP_ANDI, 1, 8, imm2));
        prog.push_back(itype(OP_ORI, 1, 9, imm2));
        prog.push_back(rtype(OP_SHIFT, 0, 2, 10, sh, 0));
        prog.push_back(rtype(OP_SHIFT, 0, 2, 11, sh, 1));
        prog.push_back(rtype(OP_SLT, 1, 2, 12, 0, 0));
        prog.push_back(itype(OP_SLTI, 1, 13, imm1));
        prog.push_back(rtype(OP_SLT, 2, 1, 14, 0, 0));
        // Registers 3 to 14 go to data words 16 to 27
        for (int k = 0; k < 12; k++) begin
            prog.push_back(itype(OP_SW, 0, 3 + k, 16 + k));
        end
        prog.push_back(itype(OP_SW, 0, 0, 40));
        exp.push_back(a + sext1);
        exp.push_back(a + b);
        exp.push_back(a - b);
        exp.push_back(a & b);
        exp.push_back(a | b);
        exp.push_back(a & zext2);
        exp.push_back(a | zext2);
        exp.push_back(b << sh);
        exp.push_back(b >> sh);
        exp.push_back(($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        exp.push_back(($signed(a) < $signed(sext1)) ? 32'd1 : 32'd0);
        exp.push_back(($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        load_program(prog);
        pulse_start();
        wait_for_halt();
        for (int k = 0; k < 12; k++) begin
            read_word(DMEM + 16 + k, got);
            compare_word({names[k], " result"}, got, exp[k]);
        end
        read_word(DMEM + 40, got);
        compare_word("store from register 0", got, 32'd0);
    endtask

    // Countdown loop with bne, then a taken beq and a j that each skip a store
    task automatic branch_program();
        int          n;
        logic [31:0] step;
        logic [31:0] p1;
        logic [31:0] p2;
        logic [31:0] got;
        logic [31:0] prog [$];
        n    = ($random(seed) & 7) + 1;
        step = $random(seed);
        p1   = $random(seed);
        p2   = $random(seed);
        apply_reset();
        write_word(DMEM + 0, 32'(n));
        write_word(DMEM + 1, step);
        write_word(DMEM + 50, p1);
        write_word(DMEM + 51, p2);
        prog.push_back(itype(OP_LW, 0, 1, 0));
        prog.push_back(itype(OP_LW, 0, 2, 1));
        prog.push_back(itype(OP_ADDI, 0, 3, 0));
        // Loop body starts at word 3
        prog.push_back(rtype(OP_RTYPE, 3, 2, 3, 0, 0));
        prog.push_back(itype(OP_ADDI, 1, 1, -1));
        prog.push_back(itype(OP_BNE, 1, 0, -3));
        prog.push_back(itype(OP_SW, 0, 1, 2));
        prog.push_back(itype(OP_SW, 0, 3, 3));
        prog.push_back(itype(OP_BEQ, 0, 0, 1));
        prog.push_back(itype(OP_SW, 0, 2, 50));
        prog.push_back(jtype(OP_J, 12));
        prog.push_back(itype(OP_SW, 0, 2, 51));
        prog.push_back(itype(OP_SW, 0, 2, 4));
        load_program(prog);
        pulse_start();
        wait_for_halt();
        read_word(DMEM + 2, got);
        compare_word("loop counter after bne loop", got, 32'd0);
        read_word(DMEM + 3, got);
        compare_word("loop accumulator", got, 32'(n) * step);
        read_word(DMEM + 4, got);
        compare_word("store after the jump", got, step);
        read_word(DMEM + 50, got);
        compare_word("word skipped by beq", got, p1);
        read_word(DMEM + 51, got);
        compare_word("word skipped by j", got, p2);
    endtask

    // A read issued while the core runs must wait for halt and see its result
    task automatic backpressure_program();
        logic [31:0] v;
        logic [31:0] got;
        logic [31:0] prog [$];
        v = $random(seed);
        apply_reset();
        write_word(DMEM + 0, v);
        write_word(DMEM + 61, ~v);
        prog.push_back(itype(OP_LW, 0, 1, 0));
        prog.push_back(itype(OP_ADDI, 0, 2, 8));
        prog.push_back(itype(OP_ADDI, 2, 2, -1));
        prog.push_back(itype(OP_BNE, 2, 0, -2));
        prog.push_back(itype(OP_ADDI, 1, 1, 5));
        prog.push_back(itype(OP_SW, 0, 1, 61));
        load_program(prog);
        pulse_start();
        compare_word("running after start", 32'(running), 32'd1);
        read_word(DMEM + 61, got);
        compare_word("halted when the held read completes", 32'(halted), 32'd1);
        compare_word("held read data", got, v + 32'd5);
        wait_for_halt();
    endtask

    // The word after the program holds an old store that must never run
    task automatic halt_program();
        logic [31:0] p;
        logic [31:0] got;
        logic [31:0] prog [$];
        p = $random(seed) | 32'd1;
        apply_reset();
        write_word(3, itype(OP_SW, 0, 1, 70));
        // Memory keeps its words but the program length starts over
        apply_reset();
        write_word(DMEM + 70, p);
        write_word(DMEM + 71, 32'd0);
        prog.push_back(itype(OP_ADDI, 0, 1, 16'h0055));
        prog.push_back(itype(OP_SW, 0, 1, 71));
        prog.push_back(itype(OP_ADDI, 1, 1, 1));
        load_program(prog);
        pulse_start();
        wait_for_halt();
        compare_word("halted at program end", 32'(halted), 32'd1);
        compare_word("running at program end", 32'(running), 32'd0);
        read_word(DMEM + 71, got);
        compare_word("store inside the program", got, 32'h0000_0055);
        read_word(DMEM + 70, got);
        compare_word("word behind the program end", got, p);
        // A new start after halt is ignored
        pulse_start();
        @(negedge clk);
        compare_word("running after start while halted", 32'(running), 32'd0);
    endtask

    initial begin
        seed     = 77;
        errors   = 0;
        timeouts = 0;
        rst_n    = 1'b0;
        start    = 1'b0;
        wb_req   = '0;
        check_reset_state();
        alu_program();
        branch_program();
        backpressure_program();
        halt_program();
        $display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: src/cpu_top.sv
`include "cpu_config.svh"

module cpu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::wb_req_t  wb_req,
    output cpu_pkg::wb_rsp_t  wb_rsp,
    input  logic              start,
    output logic              running,
    output logic              halted
);
    import cpu_pkg::*;

    // Port A of both memories belongs to the host side
    mem_req_t imem_a_req;
    mem_req_t dmem_a_req;
    logic [`CPU_XLEN-1:0] imem_a_rdata;
    logic [`CPU_XLEN-1:0] dmem_a_rdata;

    // Port B of both memories belongs to the core
    mem_req_t imem_b_req;
    mem_req_t dmem_b_req;
    logic [`CPU_XLEN-1:0] imem_b_rdata;
    logic [`CPU_XLEN-1:0] dmem_b_rdata;

    // Number of loaded instructions, the core halts when its PC gets there
    logic [`CPU_BUS_AW-1:0] prog_len;

    host_port i_host_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .running    (running),
        .imem_req   (imem_a_req),
        .dmem_req   (dmem_a_req),
        .imem_rdata (imem_a_rdata),
        .dmem_rdata (dmem_a_rdata),
        .prog_len   (prog_len)
    );

    word_ram i_imem (
        .clk     (clk),
        .a_req   (imem_a_req),
        .a_rdata (imem_a_rdata),
        .b_req   (imem_b_req),
        .b_rdata (imem_b_rdata)
    );

    word_ram i_dmem (
        .clk     (clk),
        .a_req   (dmem_a_req),
        .a_rdata (dmem_a_rdata),
        .b_req   (dmem_b_req),
        .b_rdata (dmem_b_rdata)
    );

    core_ctrl i_core_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .prog_len   (prog_len),
        .imem_req   (imem_b_req),
        .imem_rdata (imem_b_rdata),
        .dmem_req   (dmem_b_req),
        .dmem_rdata (dmem_b_rdata),
        .running    (running),
        .halted     (halted)
    );

endmodule

// File: src/core_ctrl.sv
`include "cpu_config.svh"

module core_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [`CPU_BUS_AW-1:0] prog_len,
    output cpu_pkg::mem_req_t      imem_req,
    input  logic [`CPU_XLEN-1:0]   imem_rdata,
    output cpu_pkg::mem_req_t      dmem_req,
    input  logic [`CPU_XLEN-1:0]   dmem_rdata,
    output logic                   running,
    output logic                   halted
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_MEM,
        S_DONE
    } state_e;

    state_e                 state;
    logic [`CPU_BUS_AW-1:0] pc;
    logic [`CPU_BUS_AW-1:0] pc_plus1;
    logic [`CPU_BUS_AW-1:0] br_target;
    instr_u                 ir;
    instr_u                 fetched;

    // Decode results are computed from the fetched word and held for execute
    alu_op_e              dec_op;
    logic                 dec_use_imm;
    logic [`CPU_XLEN-1:0] dec_imm;
    logic                 dec_wr;
    logic                 dec_rd;
    alu_op_e              alu_op_q;
    logic                 use_imm_q;
    logic [`CPU_XLEN-1:0] imm_q;
    logic                 wr_q;
    logic                 dst_rd_q;

    // Register file and ALU connections
    logic [`CPU_XLEN-1:0] rs_data;
    logic [`CPU_XLEN-1:0] rt_data;
    logic [`CPU_RAW-1:0]  wr_idx;
    logic                 wr_en;
    logic [`CPU_XLEN-1:0] wr_data;
    logic [`CPU_XLEN-1:0] alu_b;
    logic [`CPU_XLEN-1:0] alu_result;
    logic                 alu_zero;

    assign fetched = imem_rdata;

    always_comb begin
        dec_op      = ALU_ADD;
        dec_use_imm = 1'b0;
        dec_imm     = {{(`CPU_XLEN-16){fetched.i.imm[15]}}, fetched.i.imm};
        dec_wr      = 1'b0;
        dec_rd      = 1'b0;
        case (fetched.r.opcode)
            OP_RTYPE: begin
                dec_op = (fetched.r.funct == 6'd1) ? ALU_SUB : ALU_ADD;
                dec_wr = 1'b1;
                dec_rd = 1'b1;
            end
            OP_AND, OP_OR, OP_SLT: begin
                dec_op = (fetched.r.opcode == OP_AND) ? ALU_AND :
                         (fetched.r.opcode == OP_OR)  ? ALU_OR  : ALU_SLT;
                dec_wr = 1'b1;
                dec_rd = 1'b1;
            end
            OP_SHIFT: begin
                dec_op = (fetched.r.funct == 6'd1) ? ALU_SRL : ALU_SLL;
                dec_wr = 1'b1;
                dec_rd = 1'b1;
            end
            OP_ADDI, OP_SLTI: begin
                dec_op      = (fetched.i.opcode == OP_SLTI) ? ALU_SLT : ALU_ADD;
                dec_use_imm = 1'b1;
                dec_wr      = 1'b1;
            end
            // Logical immediates are zero extended
            OP_ANDI, OP_ORI: begin
                dec_op      = (fetched.i.opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                dec_use_imm = 1'b1;
                dec_imm     = {{(`CPU_XLEN-16){1'b0}}, fetched.i.imm};
                dec_wr      = 1'b1;
            end
            // Effective address is rs plus the immediate
            OP_LW, OP_SW: begin
                dec_use_imm = 1'b1;
            end
            // Branches compare rs with rt, the immediate is kept as offset
            OP_BEQ, OP_BNE: begin
                dec_op = ALU_SUB;
            end
            default: begin
                dec_op = ALU_ADD;
            end
        endcase
    end

    assign pc_plus1  = pc + `CPU_BUS_AW'(1);
    assign br_target = pc_plus1 + imm_q[`CPU_BUS_AW-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            pc      <= '0;
            running <= 1'b0;
            halted  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state   <= S_FETCH;
                        pc      <= '0;
                        running <= 1'b1;
                    end
                end
                // The PC reaching the program end stops the core for good
                S_FETCH: begin
                    if (pc == prog_len) begin
                        state   <= S_DONE;
                        running <= 1'b0;
                        halted  <= 1'b1;
                    end else begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    state <= S_EXEC;
                end
                S_EXEC: begin
                    if (ir.i.opcode == OP_BEQ && alu_zero) begin
                        pc <= br_target;
                    end else if (ir.i.opcode == OP_BNE && !alu_zero) begin
                        pc <= br_target;
                    end else if (ir.j.opcode == OP_J) begin
                        pc <= ir.j.target[`CPU_BUS_AW-1:0];
                    end else begin
                        pc <= pc_plus1;
                    end
                    state <= (ir.i.opcode == OP_LW) ? S_MEM : S_FETCH;
                end
                S_MEM: begin
                    state <= S_FETCH;
                end
                default: begin
                    state <= S_DONE;
                end
            endcase
        end
    end

    // Instruction register and decode results load at the end of decode
    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            ir        <= fetched;
            alu_op_q  <= dec_op;
            use_imm_q <= dec_use_imm;
            imm_q     <= dec_imm;
            wr_q      <= dec_wr;
            dst_rd_q  <= dec_rd;
        end
    end

    // Fetch presents the PC and the word is back in decode
    assign imem_req.we    = 1'b0;
    assign imem_req.addr  = pc[`CPU_MEM_AW-1:0];
    assign imem_req.wdata = '0;

    // Loads and stores address data memory in execute
    assign dmem_req.we    = (state == S_EXEC) && (ir.i.opcode == OP_SW);
    assign dmem_req.addr  = alu_result[`CPU_MEM_AW-1:0];
    assign dmem_req.wdata = rt_data;

    // ALU results write back in execute, load data in the memory cycle
    assign wr_en   = ((state == S_EXEC) && wr_q) || (state == S_MEM);
    assign wr_idx  = ((state == S_EXEC) && dst_rd_q) ? ir.r.rd : ir.i.rt;
    assign wr_data = (state == S_MEM) ? dmem_rdata : alu_result;

    assign alu_b = use_imm_q ? imm_q : rt_data;

    reg_file i_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_idx  (ir.r.rs),
        .rt_idx  (ir.r.rt),
        .wr_idx  (wr_idx),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu i_alu (
        .op     (alu_op_q),
        .a      (rs_data),
        .b      (alu_b),
        .shamt  (ir.r.shamt),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // A store belongs to a running core and never writes a register back
    a_store_no_writeback: assert property (
        @(posedge clk) disable iff (!rst_n)
        dmem_req.we |-> running && !wr_en
    );

    a_run_xor_halt: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(running && halted)
    );

endmodule

// File: src/host_port.sv
`include "cpu_config.svh"

module host_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_pkg::wb_req_t       wb_req,
    output cpu_pkg::wb_rsp_t       wb_rsp,
    input  logic                   running,
    output cpu_pkg::mem_req_t      imem_req,
    output cpu_pkg::mem_req_t      dmem_req,
    input  logic [`CPU_XLEN-1:0]   imem_rdata,
    input  logic [`CPU_XLEN-1:0]   dmem_rdata,
    output logic [`CPU_BUS_AW-1:0] prog_len
);
    logic                   sel_dmem;
    logic                   access;
    logic                   ack_q;
    logic                   sel_q;
    logic [`CPU_BUS_AW-1:0] wr_end;

    assign sel_dmem = wb_req.adr[`CPU_BUS_SEL];

    // A request is taken once, only while the core is stopped
    // The ack pulse itself blocks a second access to the same request
    assign access = wb_req.cyc && wb_req.stb && !running && !ack_q;

    // Both RAMs see the address and data, only the selected one gets the write
    always_comb begin
        imem_req.we    = access && wb_req.we && !sel_dmem;
        imem_req.addr  = wb_req.adr[`CPU_MEM_AW-1:0];
        imem_req.wdata = wb_req.dat_w;
        dmem_req.we    = access && wb_req.we && sel_dmem;
        dmem_req.addr  = wb_req.adr[`CPU_MEM_AW-1:0];
        dmem_req.wdata = wb_req.dat_w;
    end

    // Program length if this write turns out to be the highest instruction
    assign wr_end = `CPU_BUS_AW'(wb_req.adr[`CPU_MEM_AW-1:0]) + `CPU_BUS_AW'(1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            prog_len <= '0;
        end else begin
            ack_q <= access;
            if (imem_req.we && wr_end > prog_len) begin
                prog_len <= wr_end;
            end
        end
    end

    // Remembers which memory answers in the ack cycle
    always_ff @(posedge clk) begin
        if (access) begin
            sel_q <= sel_dmem;
        end
    end

    // The RAM word arrives one cycle after the access, together with ack
    assign wb_rsp.ack   = ack_q && wb_req.cyc && wb_req.stb;
    assign wb_rsp.dat_r = sel_q ? dmem_rdata : imem_rdata;

    // The host is never answered while the core owns the memories
    a_ack_core_stopped: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> !running
    );

endmodule

// File: src/alu.sv
`include "cpu_config.svh"

module alu (
    input  cpu_pkg::alu_op_e     op,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    input  logic [4:0]           shamt,
    output logic [`CPU_XLEN-1:0] result,
    output logic                 zero
);
    import cpu_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            // Shifts act on the second operand, as in the R type shift format
            ALU_SLL: begin
                result = b << shamt;
            end
            ALU_SRL: begin
                result = b >> shamt;
            end
            // Signed compare gives 1 or 0
            ALU_SLT: begin
                result = ($signed(a) < $signed(b)) ? `CPU_XLEN'(1) : '0;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // With op sub this tells whether both operands are equal
    assign zero = (result == '0);

endmodule

// File: src/reg_file.sv
`include "cpu_config.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`CPU_RAW-1:0]  rs_idx,
    input  logic [`CPU_RAW-1:0]  rt_idx,
    input  logic [`CPU_RAW-1:0]  wr_idx,
    input  logic                 wr_en,
    input  logic [`CPU_XLEN-1:0] wr_data,
    output logic [`CPU_XLEN-1:0] rs_data,
    output logic [`CPU_XLEN-1:0] rt_data
);
    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    // Register 0 is never written, so after reset it reads zero for good
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Reads are combinational, a write shows up after the clock edge
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

endmodule

// File: src/word_ram.sv
`include "cpu_config.svh"

module word_ram (
    input  logic                 clk,
    input  cpu_pkg::mem_req_t    a_req,
    output logic [`CPU_XLEN-1:0] a_rdata,
    input  cpu_pkg::mem_req_t    b_req,
    output logic [`CPU_XLEN-1:0] b_rdata
);
    // Contents are whatever the host loads, nothing clears them
    logic [`CPU_XLEN-1:0] mem [`CPU_MEM_WORDS];

    // Both ports write in one process so the array has a single driver
    // A read in the same cycle as a write to that word returns the old value
    always_ff @(posedge clk) begin
        if (a_req.we) begin
            mem[a_req.addr] <= a_req.wdata;
        end
        if (b_req.we) begin
            mem[b_req.addr] <= b_req.wdata;
        end
        a_rdata <= mem[a_req.addr];
        b_rdata <= mem[b_req.addr];
    end

    // Host and core never store to the same word at once
    a_no_write_clash: assert property (
        @(posedge clk)
        (a_req.we && b_req.we) |-> (a_req.addr != b_req.addr)
    );

endmodule

// File: src/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    // One Wishbone classic request as driven by the host
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`CPU_BUS_AW-1:0] adr;
        logic [`CPU_XLEN-1:0]   dat_w;
    } wb_req_t;

    // Slave answer, read data is only meaningful while ack is high
    typedef struct packed {
        logic                 ack;
        logic [`CPU_XLEN-1:0] dat_r;
    } wb_rsp_t;

    // One access on a RAM port
    typedef struct packed {
        logic                   we;
        logic [`CPU_MEM_AW-1:0] addr;
        logic [`CPU_XLEN-1:0]   wdata;
    } mem_req_t;

    // Register format with shift amount and function field
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    // Immediate format used by ALU immediates, loads, stores and branches
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // Jump format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fmt_t;

    // The same instruction word seen through each of the three formats
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    // Opcodes that the core executes, all others behave as a no-op
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd1,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_ANDI  = 6'd5,
        OP_ORI   = 6'd6,
        OP_SHIFT = 6'd7,
        OP_LW    = 6'd8,
        OP_SW    = 6'd9,
        OP_BEQ   = 6'd10,
        OP_BNE   = 6'd11,
        OP_J     = 6'd16,
        OP_SLT   = 6'd19,
        OP_SLTI  = 6'd20
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_e;

endpackage

// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Width of every data word, instruction word and register
`define CPU_XLEN 32

// Each memory holds this many words and is addressed by word
`define CPU_MEM_WORDS 256
`define CPU_MEM_AW 8

// General register file size and index width
`define CPU_NREGS 32
`define CPU_RAW 5

// Host bus word address width
`define CPU_BUS_AW 9

// Address bit that picks the memory behind the host bus
// Zero selects instruction memory and one selects data memory
`define CPU_BUS_SEL 8

`endif
